/* clock_display.f */
clock_pkg.sv
time_keeper.sv
field_editor.sv
display_formatter.sv
clock_display.sv
tb_clock_display.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert --top-module tb_clock_display \
  -f clock_display.f -o sim_clock_display
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

output=$(./obj_dir/sim_clock_display)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

if echo "$output" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1

/* tb_clock_display.sv */
`timescale 1ns/1ps

module tb_clock_display;
  import clock_pkg::*;

  logic       clk;
  logic       rst_n;
  disp_mode_e mode;
  logic       tick;
  logic       up_press;
  led_t       led0, led1, led2, led3, led4, led5, led6, led7;

  // reference model keeps the time of day as seconds since midnight
  int         tod;
  int         e_h;
  int         e_m;
  int         e_s;
  disp_mode_e last_mode;
  logic       commit_due;
  logic       reset_seen = 1'b0;

  logic        shown_valid;
  disp_mode_e  shown_mode;
  int          shown_tod;
  logic [23:0] shown_edit;
  logic        commit_loaded;
  logic        commit_shown;
  logic [23:0] loaded_time;

  logic [47:0] all_leds;
  logic [23:0] shown_time;  // hh mm ss digits read off the display
  logic [23:0] exp_time;
  logic [23:0] edit_bcd;
  logic [7:0]  blink_bits;
  logic [7:0]  exp_blink;
  logic [7:0]  dot_bits;
  logic [7:0]  separators;

  logic [31:0] rng;
  int          reset_errs = 0;
  int          time_errs = 0;
  int          layout_errs = 0;
  int          timeout_errs = 0;

  clock_display i_clock_display (
    .clk      (clk),
    .rst_n    (rst_n),
    .mode     (mode),
    .tick     (tick),
    .up_press (up_press),
    .led0     (led0),
    .led1     (led1),
    .led2     (led2),
    .led3     (led3),
    .led4     (led4),
    .led5     (led5),
    .led6     (led6),
    .led7     (led7)
  );

  always #5 clk = ~clk;

  function automatic logic [7:0] to_bcd(input int value);
    logic [7:0] bcd;
    bcd = 8'(((value / 10) << 4) + (value % 10));
    return bcd;
  endfunction

  function automatic logic [23:0] tod_bcd(input int secs);
    return {to_bcd(secs / 3600), to_bcd((secs / 60) % 60), to_bcd(secs % 60)};
  endfunction

  function automatic logic [7:0] blink_for(input disp_mode_e m);
    logic [7:0] mask;
    case (m)
      mode_edit_second: mask = 8'h03;  // led1 led0
      mode_edit_minute: mask = 8'h18;  // led4 led3
      mode_edit_hour:   mask = 8'hc0;
      default:          mask = 8'h00;
    endcase
    return mask;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_below(input int n);
    rng = xorshift(rng);
    return int'(rng % n);
  endfunction

  function automatic int edit_value(input disp_mode_e m);
    int value;
    case (m)
      mode_edit_second: value = e_s;
      mode_edit_minute: value = e_m;
      default:          value = e_h;
    endcase
    return value;
  endfunction

  assign all_leds   = {led7, led6, led5, led4, led3, led2, led1, led0};
  assign shown_time = {led7.digit, led6.digit, led4.digit, led3.digit, led1.digit, led0.digit};
  assign blink_bits = {led7.blink, led6.blink, led5.blink, led4.blink,
                       led3.blink, led2.blink, led1.blink, led0.blink};
  assign dot_bits   = {led7.dot, led6.dot, led5.dot, led4.dot,
                       led3.dot, led2.dot, led1.dot, led0.dot};
  assign separators = {led5.digit, led2.digit};
  assign edit_bcd   = {to_bcd(e_h), to_bcd(e_m), to_bcd(e_s)};
  assign exp_time   = tod_bcd(shown_tod);
  assign exp_blink  = blink_for(shown_mode);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reset_seen    <= 1'b1;
      tod           <= 0;
      e_h           <= 0;
      e_m           <= 0;
      e_s           <= 0;
      last_mode     <= mode_time_disp;
      commit_due    <= 1'b0;
      shown_valid   <= 1'b0;
      shown_mode    <= mode_time_disp;
      shown_tod     <= 0;
      shown_edit    <= '0;
      commit_loaded <= 1'b0;
      commit_shown  <= 1'b0;
      loaded_time   <= '0;
    end else begin
      last_mode  <= mode;
      commit_due <= (mode == mode_time_disp) && (last_mode != mode_time_disp);
      if (commit_due) begin
        tod <= e_h * 3600 + e_m * 60 + e_s;
        loaded_time <= edit_bcd;
      end else if (tick) begin
        tod <= (tod + 1) % 86400;  // 23:59:59 rolls to midnight
      end
      if (mode == mode_time_disp) begin
        if (last_mode == mode_time_disp) begin
          e_h <= tod / 3600;
          e_m <= (tod / 60) % 60;
          e_s <= tod % 60;
        end
      end else if (up_press) begin
        case (mode)
          mode_edit_second: e_s <= (e_s + 1) % 60;
          mode_edit_minute: e_m <= (e_m + 1) % 60;
          default:          e_h <= (e_h + 1) % 24;
        endcase
      end
      shown_valid   <= 1'b1;
      shown_mode    <= mode;
      shown_tod     <= tod;
      shown_edit    <= edit_bcd;
      commit_loaded <= commit_due;
      commit_shown  <= commit_loaded;  // display picks up the loaded time here
    end
  end

  a_reset : assert property (@(posedge clk) (!rst_n && reset_seen) |-> (all_leds == '0))
  else begin
    reset_errs++;
    $display("Fail %0t all_leds expected %h got %h", $time, 48'h0, $sampled(all_leds));
  end

  a_count : assert property (@(posedge clk) disable iff (!rst_n)
    (shown_valid && shown_mode == mode_time_disp) |-> (shown_time == exp_time))
  else begin
    time_errs++;
    $display("Fail %0t shown_time expected %h got %h", $time,
             $sampled(exp_time), $sampled(shown_time));
  end

  a_edit : assert property (@(posedge clk) disable iff (!rst_n)
    (shown_valid && shown_mode != mode_time_disp) |-> (shown_time == shown_edit))
  else begin
    time_errs++;
    $display("Fail %0t shown_time expected %h got %h", $time,
             $sampled(shown_edit), $sampled(shown_time));
  end

  a_commit : assert property (@(posedge clk) disable iff (!rst_n)
    (commit_shown && shown_mode == mode_time_disp) |-> (shown_time == loaded_time))
  else begin
    time_errs++;
    $display("Fail %0t shown_time expected %h got %h", $time,
             $sampled(loaded_time), $sampled(shown_time));
  end

  a_separators : assert property (@(posedge clk) disable iff (!rst_n)
    shown_valid |-> (separators == 8'haa))
  else begin
    layout_errs++;
    $display("Fail %0t separators expected aa got %h", $time, $sampled(separators));
  end

  a_dots : assert property (@(posedge clk) disable iff (!rst_n)
    shown_valid |-> (dot_bits == 8'hff))
  else begin
    layout_errs++;
    $display("Fail %0t dot_bits expected ff got %h", $time, $sampled(dot_bits));
  end

  a_blink : assert property (@(posedge clk) disable iff (!rst_n)
    shown_valid |-> (blink_bits == exp_blink))
  else begin
    layout_errs++;
    $display("Fail %0t blink_bits expected %h got %h", $time,
             $sampled(exp_blink), $sampled(blink_bits));
  end

  task automatic tick_until(input int target, input int limit);
    int cycles;
    int gap;
    cycles = 0;
    while (tod != target && cycles < limit) begin
      gap = 1 + rand_below(3);  // keeps ticks apart
      repeat (gap) @(negedge clk);
      tick = 1'b1;
      @(negedge clk);
      tick = 1'b0;
      cycles = cycles + gap + 1;
    end
    if (tod != target) begin
      timeout_errs++;
      $display("timeout: time of day never reached %0d s within %0d cycles", target, limit);
    end
  endtask

  task automatic press_times(input disp_mode_e m, input int count);
    mode = m;
    @(negedge clk);
    repeat (count) begin
      up_press = 1'b1;
      @(negedge clk);
      up_press = 1'b0;
      @(negedge clk);
    end
  endtask

  task automatic press_until(input disp_mode_e m, input int target, input int limit);
    int presses;
    presses = 0;
    mode = m;
    @(negedge clk);
    while (edit_value(m) != target && presses < limit) begin
      up_press = 1'b1;
      @(negedge clk);
      up_press = 1'b0;
      @(negedge clk);
      presses++;
    end
    if (edit_value(m) != target) begin
      timeout_errs++;
      $display("timeout: edit field never reached %0d after %0d presses", target, limit);
    end
  endtask

  task automatic commit_and_wait(input int limit);
    int cycles;
    cycles = 0;
    mode = mode_time_disp;
    @(negedge clk);
    while (!commit_shown && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!commit_shown) begin
      timeout_errs++;
      $display("timeout: edited time never reached the display");
    end
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    mode     = mode_time_disp;
    tick     = 1'b0;
    up_press = 1'b0;
    rng      = 32'd6;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    tick_until(75, 1000);  // past the first seconds carry
    press_times(mode_edit_second, 60 + rand_below(20));
    press_times(mode_edit_minute, 60 + rand_below(20));
    press_times(mode_edit_hour, 24 + rand_below(10));
    commit_and_wait(8);
    tick_until((tod + 7) % 86400, 100);
    press_until(mode_edit_second, 50, 80);
    press_until(mode_edit_minute, 59, 80);
    press_until(mode_edit_hour, 23, 40);
    commit_and_wait(8);
    tick_until(10, 200);  // minute and hour carries into the next day
    repeat (3) @(negedge clk);
    $display("errors: reset %0d, time %0d, layout %0d, timeout %0d",
             reset_errs, time_errs, layout_errs, timeout_errs);
    if (reset_errs + time_errs + layout_errs + timeout_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* clock_display.sv */
`timescale 1ns/1ps

module clock_display #(
  parameter clock_pkg::bcd2_t hour_max = 8'h23  // 8'h11 for a 0-11 face
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  clock_pkg::disp_mode_e mode,
  input  logic                  tick,
  input  logic                  up_press,
  output clock_pkg::led_t       led0,
  output clock_pkg::led_t       led1,
  output clock_pkg::led_t       led2,
  output clock_pkg::led_t       led3,
  output clock_pkg::led_t       led4,
  output clock_pkg::led_t       led5,
  output clock_pkg::led_t       led6,
  output clock_pkg::led_t       led7
);
  import clock_pkg::*;

  bcd2_t hour;
  bcd2_t minute;
  bcd2_t second;
  bcd2_t edit_hour;
  bcd2_t edit_minute;
  bcd2_t edit_second;
  logic  load;

  time_keeper #(
    .hour_max(hour_max)
  ) i_time_keeper (
    .clk         (clk),
    .rst_n       (rst_n),
    .tick        (tick),
    .load        (load),
    .edit_hour   (edit_hour),
    .edit_minute (edit_minute),
    .edit_second (edit_second),
    .hour        (hour),
    .minute      (minute),
    .second      (second)
  );

  field_editor #(
    .hour_max(hour_max)
  ) i_field_editor (
    .clk         (clk),
    .rst_n       (rst_n),
    .mode        (mode),
    .up_press    (up_press),
    .hour        (hour),
    .minute      (minute),
    .second      (second),
    .edit_hour   (edit_hour),
    .edit_minute (edit_minute),
    .edit_second (edit_second),
    .load        (load)
  );

  display_formatter i_display_formatter (
    .clk         (clk),
    .rst_n       (rst_n),
    .mode        (mode),
    .hour        (hour),
    .minute      (minute),
    .second      (second),
    .edit_hour   (edit_hour),
    .edit_minute (edit_minute),
    .edit_second (edit_second),
    .led0        (led0),
    .led1        (led1),
    .led2        (led2),
    .led3        (led3),
    .led4        (led4),
    .led5        (led5),
    .led6        (led6),
    .led7        (led7)
  );

endmodule

/* display_formatter.sv */
`timescale 1ns/1ps

module display_formatter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  clock_pkg::disp_mode_e mode,
  input  clock_pkg::bcd2_t      hour,
  input  clock_pkg::bcd2_t      minute,
  input  clock_pkg::bcd2_t      second,
  input  clock_pkg::bcd2_t      edit_hour,
  input  clock_pkg::bcd2_t      edit_minute,
  input  clock_pkg::bcd2_t      edit_second,
  output clock_pkg::led_t       led0,
  output clock_pkg::led_t       led1,
  output clock_pkg::led_t       led2,
  output clock_pkg::led_t       led3,
  output clock_pkg::led_t       led4,
  output clock_pkg::led_t       led5,
  output clock_pkg::led_t       led6,
  output clock_pkg::led_t       led7
);
  import clock_pkg::*;

  bcd2_t      src_hour;
  bcd2_t      src_minute;
  bcd2_t      src_second;
  logic [7:0] blink_mask;  // bit n blinks led n

  function automatic led_t make_led(input logic blink, input digit_t digit);
    led_t word;
    word.blink = blink;
    word.dot   = 1'b1;  // dots always lit
    word.digit = digit;
    return word;
  endfunction

  // live time on display, working copy while editing
  always_comb begin
    if (mode == mode_time_disp) begin
      src_hour   = hour;
      src_minute = minute;
      src_second = second;
    end else begin
      src_hour   = edit_hour;
      src_minute = edit_minute;
      src_second = edit_second;
    end
  end

  always_comb begin
    case (mode)
      mode_edit_second: blink_mask = 8'b0000_0011;
      mode_edit_minute: blink_mask = 8'b0001_1000;
      mode_edit_hour:   blink_mask = 8'b1100_0000;
      default:          blink_mask = 8'b0000_0000;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led0 <= '0;
      led1 <= '0;
      led2 <= '0;
      led3 <= '0;
      led4 <= '0;
      led5 <= '0;
      led6 <= '0;
      led7 <= '0;
    end else begin
      led7 <= make_led(blink_mask[7], src_hour[7:4]);
      led6 <= make_led(blink_mask[6], src_hour[3:0]);
      led5 <= make_led(blink_mask[5], digit_separator);
      led4 <= make_led(blink_mask[4], src_minute[7:4]);
      led3 <= make_led(blink_mask[3], src_minute[3:0]);
      led2 <= make_led(blink_mask[2], digit_separator);
      led1 <= make_led(blink_mask[1], src_second[7:4]);
      led0 <= make_led(blink_mask[0], src_second[3:0]);
    end
  end

endmodule

/* field_editor.sv */
`timescale 1ns/1ps

module field_editor #(
  parameter clock_pkg::bcd2_t hour_max = 8'h23
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  clock_pkg::disp_mode_e mode,
  input  logic                  up_press,
  input  clock_pkg::bcd2_t      hour,
  input  clock_pkg::bcd2_t      minute,
  input  clock_pkg::bcd2_t      second,
  output clock_pkg::bcd2_t      edit_hour,
  output clock_pkg::bcd2_t      edit_minute,
  output clock_pkg::bcd2_t      edit_second,
  output logic                  load
);
  import clock_pkg::*;

  disp_mode_e prev_mode;
  logic       in_disp;
  logic       was_disp;
  logic       commit;

  assign in_disp  = (mode == mode_time_disp);
  assign was_disp = (prev_mode == mode_time_disp);
  assign commit   = in_disp && !was_disp;  // first display cycle after editing

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_mode <= mode_time_disp;
      load      <= 1'b0;
    end else begin
      prev_mode <= mode;
      load      <= commit;
    end
  end

  // working copy of the time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edit_hour   <= 8'h00;
      edit_minute <= 8'h00;
      edit_second <= 8'h00;
    end else begin
      case (mode)
        mode_time_disp: begin
          // hold the edited value until the commit has been sampled
          if (was_disp) begin
            edit_hour   <= hour;
            edit_minute <= minute;
            edit_second <= second;
          end
        end
        mode_edit_second: begin
          if (up_press) begin
            edit_second <= bcd_inc(edit_second, minute_max);
          end
        end
        mode_edit_minute: begin
          if (up_press) begin
            edit_minute <= bcd_inc(edit_minute, minute_max);
          end
        end
        mode_edit_hour: begin
          if (up_press) begin
            edit_hour <= bcd_inc(edit_hour, hour_max);  // 23 or 11 face
          end
        end
        default: begin
          edit_hour   <= edit_hour;
          edit_minute <= edit_minute;
          edit_second <= edit_second;
        end
      endcase
    end
  end

  // commit is a single pulse
  a_load_single : assert property (
    @(posedge clk) disable iff (!rst_n)
      load |=> !load
  ) else $error("field_editor: load high on two consecutive cycles");

endmodule

/* time_keeper.sv */
`timescale 1ns/1ps

module time_keeper #(
  parameter clock_pkg::bcd2_t hour_max = 8'h23
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             tick,
  input  logic             load,
  input  clock_pkg::bcd2_t edit_hour,
  input  clock_pkg::bcd2_t edit_minute,
  input  clock_pkg::bcd2_t edit_second,
  output clock_pkg::bcd2_t hour,
  output clock_pkg::bcd2_t minute,
  output clock_pkg::bcd2_t second
);
  import clock_pkg::*;

  logic second_wrap;
  logic minute_wrap;

  assign second_wrap = (second == minute_max);
  assign minute_wrap = (minute == minute_max);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hour   <= 8'h00;
      minute <= 8'h00;
      second <= 8'h00;
    end else if (load) begin  // commit wins over tick
      hour   <= edit_hour;
      minute <= edit_minute;
      second <= edit_second;
    end else if (tick) begin
      second <= bcd_inc(second, minute_max);
      if (second_wrap) begin
        minute <= bcd_inc(minute, minute_max);
        if (minute_wrap) begin
          hour <= bcd_inc(hour, hour_max);
        end
      end
    end
  end

  // field limits hold across ticks and commits from the editor
  property p_second_range;
    @(posedge clk) disable iff (!rst_n)
      second <= minute_max;
  endproperty

  property p_minute_range;
    @(posedge clk) disable iff (!rst_n)
      minute <= minute_max;
  endproperty

  property p_hour_range;
    @(posedge clk) disable iff (!rst_n)
      hour <= hour_max;
  endproperty

  a_second_range : assert property (p_second_range)
    else $error("time_keeper: second out of range %h", second);
  a_minute_range : assert property (p_minute_range)
    else $error("time_keeper: minute out of range %h", minute);
  a_hour_range : assert property (p_hour_range)
    else $error("time_keeper: hour out of range %h", hour);

endmodule

/* clock_pkg.sv */
package clock_pkg;

  // display and edit modes, driven from outside as a level
  typedef enum logic [1:0] {
    mode_time_disp   = 2'd0,
    mode_edit_second = 2'd1,
    mode_edit_minute = 2'd2,
    mode_edit_hour   = 2'd3
  } disp_mode_e;

  // two BCD digits, tens in the upper nibble
  typedef logic [7:0] bcd2_t;

  // digit code shown on one display position
  typedef logic [3:0] digit_t;

  // one display word as seen by the LED driver
  typedef struct packed {
    logic   blink;
    logic   dot;
    digit_t digit;
  } led_t;

  localparam bcd2_t  minute_max      = 8'h59;  // seconds and minutes
  localparam digit_t digit_separator = 4'd10;

  // BCD +1 with wrap to 00 once the field sits at its limit
  function automatic bcd2_t bcd_inc(input bcd2_t value, input bcd2_t limit);
    bcd2_t next;
    if (value == limit) begin
      next = 8'h00;
    end else if (value[3:0] == 4'd9) begin
      next = {value[7:4] + 4'd1, 4'd0};  // carry into tens
    end else begin
      next = {value[7:4], value[3:0] + 4'd1};
    end
    return next;
  endfunction

endpackage
